// ==== hw/serdes_rx_pkg.sv ====
// Shared definitions for the serial receive front end
// Lock constants, received word struct, link state enum
// and link status struct
package serdes_rx_pkg;

    // ******************************
    // Constants
    // ******************************
    localparam int MAX_WIDTH = 10;               // Widest word the deserializer supports

    localparam logic [7:0] LOCK_MATCHES = 8'd4;  // Training hits in a row for lock

    // ******************************
    // Word from the deserializer
    // ******************************
    typedef struct packed {
        logic [MAX_WIDTH-1:0] bits;   // Low WIDTH bits used, first bit at WIDTH-1
        logic                 valid;  // Single-cycle pulse per word
    } rx_word_s;

    // ******************************
    // Link controller
    // ******************************
    typedef enum logic [1:0] {
        LINK_SETTLE = 2'd0,  // Waiting out the settle time
        LINK_HUNT   = 2'd1,  // Searching for training words
        LINK_LOCKED = 2'd2   // Word boundary found
    } link_state_e;

    typedef struct packed {
        link_state_e state;  // Current controller state
        logic        ready;  // High only when locked
    } link_status_s;

endpackage

// ==== hw/rx_deserializer.sv ====
`timescale 1ns/1ps
// Serial to parallel converter
// Input registers, slip strobe edge detect, shift register, bit counter
// One valid pulse per WIDTH counted bits

module rx_deserializer #(
    parameter int WIDTH = 4                          // Word width, 3 to 10
) (
    input  logic                    fabric_clk_div,
    input  logic                    reset_buf_n,     // Async, active low
    input  logic                    enable_n,        // Low to pass data
    input  logic                    data_i,          // One serial bit per cycle
    input  logic                    bitslip_ctrl_n,  // Active-low slip strobe
    output serdes_rx_pkg::rx_word_s rx_word
);

    localparam int CNT_W = $clog2(WIDTH);

    logic             data_q;       // Sampled serial bit
    logic             enable_n_q;   // Sampled enable
    logic             slip_act_q;   // Sampled strobe, active high
    logic             slip_act_d;   // Strobe from the cycle before
    logic             primed_q;     // Input regs hold a real sample
    logic             slip_evt;
    logic             bit_in;
    logic             shift_en;
    logic             word_done;
    logic [CNT_W-1:0] bit_cnt_q;
    logic [WIDTH-2:0] shift_q;      // Earlier bits of the word in progress
    logic [WIDTH-1:0] word_q;
    logic             valid_q;

    // ******************************
    // Input registers
    // ******************************
    always_ff @(posedge fabric_clk_div) begin
        data_q <= data_i;
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            enable_n_q <= 1'b1;              // Disabled until first sample
            slip_act_q <= 1'b0;
            slip_act_d <= 1'b0;
            primed_q   <= 1'b0;
        end else begin
            enable_n_q <= enable_n;
            slip_act_q <= ~bitslip_ctrl_n;
            slip_act_d <= slip_act_q;
            primed_q   <= 1'b1;              // First edge after reset loads inputs
        end
    end

    // ******************************
    // Shift and count
    // ******************************
    assign slip_evt  = slip_act_q & ~slip_act_d;            // Rising edge of strobe
    assign bit_in    = enable_n_q ? 1'b0 : data_q;          // Zero fill while disabled
    assign shift_en  = primed_q & ~slip_evt;                // Slip drops this bit
    assign word_done = shift_en && (bit_cnt_q == CNT_W'(WIDTH - 1));

    always_ff @(posedge fabric_clk_div) begin
        if (shift_en) begin
            shift_q <= {shift_q[WIDTH-3:0], bit_in};        // MSB first
        end
        if (word_done) begin
            word_q <= {shift_q, bit_in};                    // Finished word
        end
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= word_done;                           // Pulse next cycle
            if (word_done) begin
                bit_cnt_q <= '0;
            end else if (shift_en) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    // Widen into the shared word format
    always_comb begin
        rx_word                  = '0;
        rx_word.bits[WIDTH-1:0]  = word_q;
        rx_word.valid            = valid_q;
    end

    // Words are at least WIDTH cycles apart
    a_valid_single: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        (WIDTH > 1) && rx_word.valid |=> !rx_word.valid)
        else $error("rx_deserializer: valid high on consecutive cycles");

endmodule

// ==== hw/link_ready_ctrl.sv ====
`timescale 1ns/1ps
// Link bring-up controller
// Settle timer, training word match counter, lock FSM
// Drives the link status with the ready flag

module link_ready_ctrl #(
    parameter int               WIDTH         = 4,        // Word width
    parameter int               SETTLE_CYCLES = 255,      // Cycles before hunting
    parameter logic [WIDTH-1:0] TRAIN_WORD    = 4'b1100   // Training pattern
) (
    input  logic                        fabric_clk_div,
    input  logic                        reset_buf_n,      // Async, active low
    input  serdes_rx_pkg::rx_word_s     rx_word,
    output serdes_rx_pkg::link_status_s link_status
);

    localparam int SET_W = $clog2(SETTLE_CYCLES + 1);

    serdes_rx_pkg::link_state_e state_q;
    logic [SET_W-1:0]           settle_cnt_q;
    logic [7:0]                 match_cnt_q;    // Consecutive training hits
    logic                       ready_q;
    logic                       settle_done;
    logic                       train_hit;
    logic                       lock_hit;

    assign settle_done = (settle_cnt_q == SET_W'(SETTLE_CYCLES - 1));
    assign train_hit   = rx_word.valid && (rx_word.bits[WIDTH-1:0] == TRAIN_WORD);
    assign lock_hit    = train_hit && (match_cnt_q == serdes_rx_pkg::LOCK_MATCHES - 8'd1);

    // ******************************
    // Lock FSM
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state_q      <= serdes_rx_pkg::LINK_SETTLE;
            settle_cnt_q <= '0;
            match_cnt_q  <= '0;
            ready_q      <= 1'b0;
        end else begin
            case (state_q)
                serdes_rx_pkg::LINK_SETTLE: begin
                    if (settle_done) begin
                        state_q <= serdes_rx_pkg::LINK_HUNT;  // Stand-in for PLL lock
                    end else begin
                        settle_cnt_q <= settle_cnt_q + 1'b1;
                    end
                end
                serdes_rx_pkg::LINK_HUNT: begin
                    if (lock_hit) begin
                        state_q     <= serdes_rx_pkg::LINK_LOCKED;
                        ready_q     <= 1'b1;
                        match_cnt_q <= '0;
                    end else if (train_hit) begin
                        match_cnt_q <= match_cnt_q + 8'd1;
                    end else if (rx_word.valid) begin
                        match_cnt_q <= '0;                   // Any other word restarts
                    end
                end
                serdes_rx_pkg::LINK_LOCKED: begin
                    ready_q <= 1'b1;                         // Sticky until reset
                end
                default: begin
                    state_q <= serdes_rx_pkg::LINK_SETTLE;   // Unused encoding
                    ready_q <= 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        link_status.state = state_q;
        link_status.ready = ready_q;
    end

    // Lock holds until the next reset
    a_locked_sticky: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        state_q == serdes_rx_pkg::LINK_LOCKED |=> state_q == serdes_rx_pkg::LINK_LOCKED)
        else $error("link_ready_ctrl: left LINK_LOCKED without reset");

    // Ready flop tracks the state register
    a_ready_state: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        ready_q == (state_q == serdes_rx_pkg::LINK_LOCKED))
        else $error("link_ready_ctrl: ready disagrees with state");

endmodule

// ==== hw/rx_capture.sv ====
`timescale 1ns/1ps
// Output word register
// Loads valid words while the link is ready, holds otherwise

module rx_capture #(
    parameter int WIDTH = 4                              // Word width
) (
    input  logic                        fabric_clk_div,
    input  logic                        reset_buf_n,     // Async, active low
    input  serdes_rx_pkg::rx_word_s     rx_word,
    input  serdes_rx_pkg::link_status_s link_status,
    output logic [WIDTH-1:0]            data_o
);

    logic             load;
    logic [WIDTH-1:0] data_q;

    // Lock word itself arrives before ready is up
    assign load = rx_word.valid && link_status.ready;

    // ******************************
    // Output register
    // ******************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_q <= '0;
        end else if (load) begin
            data_q <= rx_word.bits[WIDTH-1:0];           // One cycle latency
        end
    end

    assign data_o = data_q;

    // Output moves only after a taken word
    a_data_stable: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        $changed(data_o) |-> $past(load))
        else $error("rx_capture: data_o changed without a captured word");

endmodule

// ==== hw/serdes_rx_top.sv ====
`timescale 1ns/1ps
// Receive front end top level
// Deserializer, link controller and capture register
// Parameters set here and passed to each block

module serdes_rx_top #(
    parameter int               WIDTH         = 4,        // Word width, 3 to 10
    parameter int               SETTLE_CYCLES = 255,      // Settle time in cycles
    parameter logic [WIDTH-1:0] TRAIN_WORD    = 4'b1100   // Training pattern
) (
    input  logic             fabric_clk_div,
    input  logic             reset_buf_n,     // Async, active low
    input  logic             enable_n,        // Low to receive
    input  logic             data_i,          // Serial data
    input  logic             bitslip_ctrl_n,  // Active-low slip strobe
    output logic [WIDTH-1:0] data_o,          // Captured word
    output logic             ready            // Link locked
);

    serdes_rx_pkg::rx_word_s     rx_word;      // Deserializer to consumers
    serdes_rx_pkg::link_status_s link_status;  // Controller to capture

    // ******************************
    // Deserializer
    // ******************************
    rx_deserializer #(
        .WIDTH          (WIDTH)
    ) rx_deserializer_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .rx_word        (rx_word)
    );

    // ******************************
    // Link controller
    // ******************************
    link_ready_ctrl #(
        .WIDTH          (WIDTH),
        .SETTLE_CYCLES  (SETTLE_CYCLES),
        .TRAIN_WORD     (TRAIN_WORD)
    ) link_ready_ctrl_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .rx_word        (rx_word),
        .link_status    (link_status)
    );

    // ******************************
    // Capture register
    // ******************************
    rx_capture #(
        .WIDTH          (WIDTH)
    ) rx_capture_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .rx_word        (rx_word),
        .link_status    (link_status),
        .data_o         (data_o)
    );

    assign ready = link_status.ready;  // Status flag to the pin

endmodule

// ==== verif/serdes_rx_tb.sv ====
`timescale 1ns/1ps
// Testbench for the serial receive front end
// Bit-level reference model, value checker, watchdog
// Directed tests for settle, lock, bit-slip, capture and enable gating

module serdes_rx_tb;

    // ******************************
    // Settings
    // ******************************
    localparam int               WIDTH          = 4;
    localparam int               SETTLE_CYCLES  = 20;        // Short settle for simulation
    localparam logic [WIDTH-1:0] TRAIN_WORD     = 4'b1100;
    localparam int               CLK_PERIOD     = 10;        // ns
    localparam int               RESET_CYCLES   = 5;
    localparam int               LOCK_WORDS_MAX = 12;        // Training words allowed per lock
    localparam int               RAND_SEED      = 65805;
    localparam int               PIPE_SLOTS     = 3;         // Input reg, shift/valid, output reg
    localparam int               WATCHDOG_CYCLES = 2 * (RESET_CYCLES + SETTLE_CYCLES)
                                                 + (2 * LOCK_WORDS_MAX + 40) * WIDTH + 100;

    typedef struct packed {
        int               due;    // Slot where the word shows on the outputs
        logic [WIDTH-1:0] bits;   // Word as grouped by the model
    } word_event_s;

    logic             fabric_clk_div;
    logic             reset_buf_n;
    logic             enable_n;
    logic             data_i;
    logic             bitslip_ctrl_n;
    logic [WIDTH-1:0] data_o;
    logic             ready;

    // Reference model state
    int               slot;               // Driven slots since reset release
    logic             slip_low_prev;      // Strobe level of the slot before
    logic             kept_bits[$];       // Bits of the word being assembled
    word_event_s      word_events[$];     // Finished words waiting for output time
    int               match_cnt;
    logic             model_ready;
    logic [WIDTH-1:0] model_data;
    int               tx_ptr;             // Next training bit, 0 is the MSB

    serdes_rx_top #(
        .WIDTH          (WIDTH),
        .SETTLE_CYCLES  (SETTLE_CYCLES),
        .TRAIN_WORD     (TRAIN_WORD)
    ) serdes_rx_top_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .data_o         (data_o),
        .ready          (ready)
    );

    always #5 fabric_clk_div = ~fabric_clk_div;      // 10 ns period

    // ******************************
    // Checking
    // ******************************
    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // ******************************
    // Reference model
    // ******************************
    // Words reach the controller and the capture register together
    task automatic apply_due_words();
        word_event_s ev;
        while (word_events.size() > 0 && word_events[0].due == slot) begin
            ev = word_events.pop_front();
            if (model_ready) begin
                model_data = ev.bits;                       // Captured only once locked
            end else if (ev.due - 1 >= SETTLE_CYCLES) begin  // Edge index of the valid pulse
                if (ev.bits == TRAIN_WORD) begin
                    match_cnt++;
                    if (match_cnt == int'(serdes_rx_pkg::LOCK_MATCHES)) begin
                        model_ready = 1'b1;                  // Lock word is not captured
                    end
                end else begin
                    match_cnt = 0;
                end
            end
        end
    endtask

    task automatic model_bit(input logic d, input logic en_n, input logic slip_n);
        logic [WIDTH-1:0] w;
        word_event_s      ev;
        if (slip_n || slip_low_prev) begin                  // First low slot is dropped
            kept_bits.push_back(en_n ? 1'b0 : d);
            if (kept_bits.size() == WIDTH) begin
                for (int i = 0; i < WIDTH; i++) begin
                    w[WIDTH-1-i] = kept_bits[i];            // First bit lands in the MSB
                end
                kept_bits.delete();
                ev.due  = slot + PIPE_SLOTS;
                ev.bits = w;
                word_events.push_back(ev);
            end
        end
        slip_low_prev = !slip_n;
    endtask

    // ******************************
    // Stimulus
    // ******************************
    // Sample at the falling edge, then drive the next slot
    task automatic drive_slot(input logic d, input logic en_n, input logic slip_n);
        @(negedge fabric_clk_div);
        apply_due_words();
        check_value("ready", 32'(ready), 32'(model_ready));
        check_value("data_o", 32'(data_o), 32'(model_data));
        reset_buf_n    = 1'b1;
        data_i         = d;
        enable_n       = en_n;
        bitslip_ctrl_n = slip_n;
        model_bit(d, en_n, slip_n);
        slot++;
    endtask

    task automatic send_word(input logic [WIDTH-1:0] w, input logic en_n);
        for (int i = 0; i < WIDTH; i++) begin
            drive_slot(w[WIDTH-1-i], en_n, 1'b1);           // MSB first
        end
    endtask

    task automatic send_train_bit(input logic slip_n);
        drive_slot(TRAIN_WORD[WIDTH-1-tx_ptr], 1'b0, slip_n);
        tx_ptr = (tx_ptr + 1) % WIDTH;
    endtask

    task automatic apply_reset();
        @(negedge fabric_clk_div);
        reset_buf_n    = 1'b0;
        data_i         = 1'b0;
        enable_n       = 1'b0;
        bitslip_ctrl_n = 1'b1;
        repeat (RESET_CYCLES - 1) begin                     // Release slot is the last one
            @(negedge fabric_clk_div);
            check_value("ready", 32'(ready), 32'd0);
            check_value("data_o", 32'(data_o), 32'd0);
        end
        slot          = 0;
        slip_low_prev = 1'b0;
        kept_bits.delete();
        word_events.delete();
        match_cnt     = 0;
        model_ready   = 1'b0;
        model_data    = '0;
        tx_ptr        = 0;
    endtask

    task automatic stream_until_lock();
        int words;
        words = 0;
        while (!model_ready && words < LOCK_WORDS_MAX) begin
            send_word(TRAIN_WORD, 1'b0);
            words++;
        end
        if (!model_ready) begin
            $display("Link did not lock within %0d training words", words);
            stop_with_failure();
        end else begin
            check_value("ready", 32'(ready), 32'd1);
        end
    endtask

    // ******************************
    // Tests
    // ******************************
    task automatic test_reset_settle();
        $display("Test: reset and settle");
        apply_reset();
        while (slot < SETTLE_CYCLES) begin
            send_word(TRAIN_WORD, 1'b0);                    // Ignored while settling
        end
        check_value("ready", 32'(ready), 32'd0);
        check_value("data_o", 32'(data_o), 32'd0);
    endtask

    task automatic test_aligned_lock();
        $display("Test: aligned lock");
        stream_until_lock();
    endtask

    task automatic test_bitslip();
        int offset;
        int guard;
        $display("Test: bit-slip alignment");
        apply_reset();
        offset = 1 + int'($urandom % 3);
        for (int i = 0; i < offset; i++) begin
            drive_slot(1'b0, 1'b0, 1'b1);                   // Filler shifts the stream
        end
        while (slot < SETTLE_CYCLES + 2 * WIDTH) begin
            send_train_bit(1'b1);                           // Misaligned words in hunt
        end
        guard = 0;
        while (kept_bits.size() != tx_ptr && guard < 8 * WIDTH) begin
            if (kept_bits.size() == 0 && !slip_low_prev) begin
                send_train_bit(1'b0);                       // One strobe per word period
            end else begin
                send_train_bit(1'b1);
            end
            guard++;
        end
        if (kept_bits.size() != tx_ptr) begin
            $display("Word boundary not aligned after %0d slots of slipping", guard);
            stop_with_failure();
        end else begin
            while (tx_ptr != 0) begin
                send_train_bit(1'b1);
            end
            send_word(TRAIN_WORD, 1'b0);
            send_word(TRAIN_WORD, 1'b0);
            send_word(~TRAIN_WORD, 1'b0);                   // Restarts the match count
            repeat (3) send_word(TRAIN_WORD, 1'b0);
            check_value("ready", 32'(ready), 32'd0);
            stream_until_lock();
        end
    endtask

    task automatic test_data_capture();
        $display("Test: data capture");
        repeat (8) send_word(WIDTH'($urandom), 1'b0);
        check_value("ready", 32'(ready), 32'd1);
    endtask

    task automatic test_enable_gating();
        logic [WIDTH-1:0] w;
        $display("Test: enable gating");
        repeat (2) begin
            w = WIDTH'($urandom) | WIDTH'(1);               // Nonzero on the wire
            send_word(w, 1'b1);
        end
        w = WIDTH'($urandom);
        for (int i = 0; i < WIDTH; i++) begin
            drive_slot(w[WIDTH-1-i], 1'b0, 1'b1);
            if (i == PIPE_SLOTS - 1) begin
                check_value("data_o", 32'(data_o), 32'd0);  // Gated word landed
            end
        end
        repeat (2) send_word(WIDTH'($urandom), 1'b0);
    endtask

    task automatic test_slip_after_lock();
        $display("Test: slip after lock");
        drive_slot(1'($urandom), 1'b0, 1'b0);               // Single strobe
        repeat (6) send_word(WIDTH'($urandom), 1'b0);
        repeat (PIPE_SLOTS) drive_slot(1'b0, 1'b0, 1'b1);   // Last word reaches data_o
        check_value("ready", 32'(ready), 32'd1);
    endtask

    // ******************************
    // Run control
    // ******************************
    initial begin
        fabric_clk_div = 1'b0;
        reset_buf_n    = 1'b0;
        enable_n       = 1'b1;
        data_i         = 1'b0;
        bitslip_ctrl_n = 1'b1;
        void'($urandom(RAND_SEED));
        test_reset_settle();
        test_aligned_lock();
        test_bitslip();
        test_data_capture();
        test_enable_gating();
        test_slip_after_lock();
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

endmodule

// ==== project.f ====
hw/serdes_rx_pkg.sv
hw/rx_deserializer.sv
hw/link_ready_ctrl.sv
hw/rx_capture.sv
hw/serdes_rx_top.sv
verif/serdes_rx_tb.sv

// ==== build.sh ====
#!/bin/sh
# Build and run the serial receive front end testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=serdes_rx_sim
LOG_FILE=sim.log

# Compile the package, RTL and testbench into one binary
verilator --binary --timing --assert \
    -f project.f \
    --top-module serdes_rx_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"

# Run and keep a log, the pipe keeps a failing run from skipping the check
"./$BUILD_DIR/$SIM_BIN" 2>&1 | tee "$LOG_FILE"

if grep -q "All tests passed!" "$LOG_FILE"; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED, see $LOG_FILE"
    exit 1
fi
